// ==== Makefile ====
# Verilator simulation of the ECC register file
TOP := tb_rf_ecc

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f rf_ecc.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== rf_ecc.f ====
rf_ecc_pkg.sv
rf_ecc_check.sv
rf_ecc_storage.sv
rf_ecc_read_ports.sv
rf_ecc_regfile.sv
tb_clock_gen.sv
rf_ecc_assert.sv
tb_rf_ecc.sv

// ==== rf_ecc_assert.sv ====
`timescale 1ns/1ps

module rf_ecc_assert
  import rf_ecc_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               gpr_we,
  input  logic [ADDR_W-1:0]  gpr_waddr,
  input  logic [DATA_W-1:0]  gpr_wdata,
  input  logic [ADDR_W-1:0]  rs1,
  input  logic [ADDR_W-1:0]  rs2,
  input  logic [DATA_W-1:0]  rs1_rdata,
  input  logic [DATA_W-1:0]  rs2_rdata,
  input  logic               alert_major,
  // Raw storage entries, taken from the DUT by hierarchy
  input  logic [ENTRY_W-1:0] mem [NUM_REGS],
  output logic               check_failed
);

  // Architectural value of every register, as last written
  logic [DATA_W-1:0]  shadow [NUM_REGS];

  // Entries currently selected by the read ports
  logic [ENTRY_W-1:0] rs1_mem;
  logic [ENTRY_W-1:0] rs2_mem;

  // Entry differs from what the last write would have stored
  logic               rs1_dirty;
  logic               rs2_dirty;
  logic [DATA_W-1:0]  rs1_exp;
  logic [DATA_W-1:0]  rs2_exp;

  // Expected alert, one cycle behind the reads
  logic               alert_exp_q;
  logic               reset_done_q;

  // Last accepted write, checked in the following cycle
  logic               wr_seen_q;
  logic [ADDR_W-1:0]  wr_addr_q;
  logic [DATA_W-1:0]  wr_data_q;
  logic [ENTRY_W-1:0] wr_mem;
  logic [ENTRY_W-1:0] wr_exp;

  // Reset image of the whole array
  logic [ENTRY_W-1:0] reset_image;
  logic               all_reset;
  logic [ENTRY_W-1:0] first_bad;

  // Entry layout for a data word, check bits on top
  function automatic logic [ENTRY_W-1:0] stored_form(input logic [DATA_W-1:0] d);
    return {ecc_encode(d), d};
  endfunction

  function automatic logic is_stuck(input logic [ENTRY_W-1:0] e);
    return (e == '0) || (e == '1);
  endfunction

  initial check_failed = 1'b0;

  // Data 0 under check value 6'h2A
  assign reset_image = {6'h2A, {DATA_W{1'b0}}};

  assign rs1_mem   = mem[rs1];
  assign rs2_mem   = mem[rs2];
  assign rs1_dirty = rs1_mem != stored_form(shadow[rs1]);
  assign rs2_dirty = rs2_mem != stored_form(shadow[rs2]);

  // x0 always reads as zero
  assign rs1_exp = (rs1 == '0) ? '0 : shadow[rs1];
  assign rs2_exp = (rs2 == '0) ? '0 : shadow[rs2];

  assign wr_mem = mem[wr_addr_q];
  assign wr_exp = stored_form(wr_data_q);

  // Lowest entry that differs from the reset value
  always_comb begin
    all_reset = 1'b1;
    first_bad = reset_image;
    for (int i = NUM_REGS - 1; i >= 0; i--) begin
      if (mem[i] != reset_image) begin
        all_reset = 1'b0;
        first_bad = mem[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NUM_REGS; i++) begin
        shadow[i] <= '0;
      end
      alert_exp_q  <= 1'b0;
      reset_done_q <= 1'b0;
      wr_seen_q    <= 1'b0;
      wr_addr_q    <= '0;
      wr_data_q    <= '0;
    end else begin
      if (gpr_we && (gpr_waddr != '0)) begin
        shadow[gpr_waddr] <= gpr_wdata;
      end
      // Any deviation from the written value counts as a fault, x0 excluded
      alert_exp_q  <= (rs1_dirty && (rs1 != '0)) || (rs2_dirty && (rs2 != '0));
      reset_done_q <= 1'b1;
      wr_seen_q    <= gpr_we && (gpr_waddr != '0);
      wr_addr_q    <= gpr_waddr;
      wr_data_q    <= gpr_wdata;
    end
  end

  // First cycle out of reset
  a_reset_contents: assert property (@(posedge clk_i)
    (rst_ni && !reset_done_q) |-> all_reset)
    else begin
      $display("FAIL a_reset_contents expected %h actual %h",
               $sampled(reset_image), $sampled(first_bad));
      check_failed = 1'b1;
    end

  a_alert_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_major == alert_exp_q)
    else begin
      $display("FAIL a_alert_match expected %0d actual %0d",
               $sampled(alert_exp_q), $sampled(alert_major));
      check_failed = 1'b1;
    end

  // Data checked only where the entry is intact, or on x0
  a_rs1_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((rs1 == '0) || !rs1_dirty) |-> (rs1_rdata == rs1_exp))
    else begin
      $display("FAIL a_rs1_data expected %h actual %h", $sampled(rs1_exp), $sampled(rs1_rdata));
      check_failed = 1'b1;
    end

  a_rs2_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((rs2 == '0) || !rs2_dirty) |-> (rs2_rdata == rs2_exp))
    else begin
      $display("FAIL a_rs2_data expected %h actual %h", $sampled(rs2_exp), $sampled(rs2_rdata));
      check_failed = 1'b1;
    end

  a_write_code: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_seen_q |-> (wr_mem == wr_exp))
    else begin
      $display("FAIL a_write_code expected %h actual %h", $sampled(wr_exp), $sampled(wr_mem));
      check_failed = 1'b1;
    end

  // A freshly written entry must never look like a stuck word
  a_clean_not_stuck: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_seen_q |-> !is_stuck(wr_mem))
    else begin
      $display("FAIL a_clean_not_stuck: a written entry is all zeros or all ones, entry %h",
               $sampled(wr_mem));
      check_failed = 1'b1;
    end

endmodule

// ==== rf_ecc_check.sv ====
`timescale 1ns/1ps

module rf_ecc_check
  import rf_ecc_pkg::*;
(
  input  logic [ENTRY_W-1:0] entry,
  output logic               fault
);

  // Halves of the stored entry
  logic [DATA_W-1:0] data;
  logic [ECC_W-1:0]  ecc_stored;

  // Code recomputed from the data half
  logic [ECC_W-1:0]  ecc_calc;
  logic [ECC_W-1:0]  syndrome;

  // Individual error flags
  logic              syndrome_err;
  logic              pattern_err;

  // Split the entry
  assign data       = entry[DATA_W-1:0];
  assign ecc_stored = entry[ENTRY_W-1:DATA_W];

  // Re-encode and compare against what was stored
  assign ecc_calc = ecc_encode(data);
  assign syndrome = ecc_calc ^ ecc_stored;

  // Detection only, no correction
  // Any nonzero syndrome means at least one flipped bit
  assign syndrome_err = |syndrome;

  // Stuck entry, data and check bits all zeros or all ones together
  // Catches a cleared or saturated word even if the code would pass
  assign pattern_err = (entry == {ENTRY_W{1'b0}}) || (entry == {ENTRY_W{1'b1}});

  // Either condition is a major fault
  assign fault = syndrome_err | pattern_err;

endmodule

// ==== rf_ecc_pkg.sv ====
package rf_ecc_pkg;

  // Architectural sizes of the register file
  localparam int unsigned NUM_REGS = 32;
  localparam int unsigned ADDR_W   = 5;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned ECC_W    = 6;

  // Stored entry layout
  // Check bits in [ENTRY_W-1:DATA_W], data in [DATA_W-1:0]
  localparam int unsigned ENTRY_W = ECC_W + DATA_W;

  // Check code column of each data bit
  // All 20 weight-3 columns plus the weight-2 columns except 0x03, 0x0C and 0x30
  // Every column has weight two or more and all columns are distinct,
  // so any 1-bit or 2-bit flip in data or check bits leaves a nonzero syndrome
  // Each check bit covers an even number of data bits, so the all-ones
  // data word encodes like zero data and never to 6'h3F
  localparam logic [ECC_W-1:0] ECC_TABLE [DATA_W] = '{
    // Weight-3 columns, data bits 0 to 19
    6'h07, 6'h0B, 6'h13, 6'h23,
    6'h0D, 6'h15, 6'h25, 6'h19,
    6'h29, 6'h31, 6'h0E, 6'h16,
    6'h26, 6'h1A, 6'h2A, 6'h32,
    6'h1C, 6'h2C, 6'h34, 6'h38,
    // Weight-2 columns, data bits 20 to 31
    6'h05, 6'h09, 6'h11, 6'h21,
    6'h06, 6'h0A, 6'h12, 6'h22,
    6'h14, 6'h24, 6'h18, 6'h28
  };

  // Inversion mask applied to every code
  // Keeps a cleared entry from being all zeros
  localparam logic [ECC_W-1:0] ECC_INVERT = 6'h2A;

  // Check code of a data word
  // Bit j is the parity of the data bits whose column has bit j set
  function automatic logic [ECC_W-1:0] ecc_encode(input logic [DATA_W-1:0] data);
    logic [ECC_W-1:0] code;
    code = '0;
    for (int unsigned i = 0; i < DATA_W; i++) begin
      // Fold in the column of every set data bit
      if (data[i]) begin
        code = code ^ ECC_TABLE[i];
      end
    end
    // Inversion last, so zero data gives 6'h2A
    return code ^ ECC_INVERT;
  endfunction

  // Reset entry
  // Data 0 with its code, which is just the inversion mask
  localparam logic [ENTRY_W-1:0] ENTRY_RESET = {ECC_INVERT, {DATA_W{1'b0}}};

endpackage

// ==== rf_ecc_read_ports.sv ====
`timescale 1ns/1ps

module rf_ecc_read_ports
  import rf_ecc_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,

  // Read addresses
  input  logic [ADDR_W-1:0]  rs1,
  input  logic [ADDR_W-1:0]  rs2,

  // Raw entries from the storage
  input  logic [ENTRY_W-1:0] rs1_entry,
  input  logic [ENTRY_W-1:0] rs2_entry,

  // Read data to the core
  output logic [DATA_W-1:0]  rs1_rdata,
  output logic [DATA_W-1:0]  rs2_rdata,

  // Registered fault pulse
  output logic               alert_major
);

  // Address decode of x0
  logic rs1_is_x0;
  logic rs2_is_x0;

  // Raw fault from each checker
  logic rs1_fault;
  logic rs2_fault;

  // Faults that count, x0 reads masked off
  logic rs1_fault_q;
  logic rs2_fault_q;

  // Next value of alert_major
  logic alert_d;

  assign rs1_is_x0 = (rs1 == '0);
  assign rs2_is_x0 = (rs2 == '0);

  // One checker per read port
  rf_ecc_check u_check_rs1 (
    .entry (rs1_entry),
    .fault (rs1_fault)
  );

  rf_ecc_check u_check_rs2 (
    .entry (rs2_entry),
    .fault (rs2_fault)
  );

  // Data half, x0 always reads as zero
  assign rs1_rdata = rs1_is_x0 ? '0 : rs1_entry[DATA_W-1:0];
  assign rs2_rdata = rs2_is_x0 ? '0 : rs2_entry[DATA_W-1:0];

  // x0 is never checked, whatever its entry holds
  assign rs1_fault_q = rs1_fault & ~rs1_is_x0;
  assign rs2_fault_q = rs2_fault & ~rs2_is_x0;

  assign alert_d = rs1_fault_q | rs2_fault_q;

  // Alert one cycle after the faulty read
  // Follows the read every cycle, so it does not stick
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      alert_major <= 1'b0;
    end else begin
      alert_major <= alert_d;
    end
  end

endmodule

// ==== rf_ecc_regfile.sv ====
`timescale 1ns/1ps

module rf_ecc_regfile
  import rf_ecc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,

  // Write port
  input  logic              gpr_we,
  input  logic [ADDR_W-1:0] gpr_waddr,
  input  logic [DATA_W-1:0] gpr_wdata,

  // Read ports
  input  logic [ADDR_W-1:0] rs1,
  input  logic [ADDR_W-1:0] rs2,
  output logic [DATA_W-1:0] rs1_rdata,
  output logic [DATA_W-1:0] rs2_rdata,

  // Major alert, one cycle after a faulty read
  output logic              alert_major
);

  // Raw entries between storage and read ports
  logic [ENTRY_W-1:0] rs1_entry;
  logic [ENTRY_W-1:0] rs2_entry;

  // Entry array with write encoding
  rf_ecc_storage u_rf_ecc_storage (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .gpr_we    (gpr_we),
    .gpr_waddr (gpr_waddr),
    .gpr_wdata (gpr_wdata),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_entry (rs1_entry),
    .rs2_entry (rs2_entry)
  );

  // Data return and fault detection
  rf_ecc_read_ports u_rf_ecc_read_ports (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_entry   (rs1_entry),
    .rs2_entry   (rs2_entry),
    .rs1_rdata   (rs1_rdata),
    .rs2_rdata   (rs2_rdata),
    .alert_major (alert_major)
  );

endmodule

// ==== rf_ecc_storage.sv ====
`timescale 1ns/1ps

module rf_ecc_storage
  import rf_ecc_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,

  // Write port
  input  logic               gpr_we,
  input  logic [ADDR_W-1:0]  gpr_waddr,
  input  logic [DATA_W-1:0]  gpr_wdata,

  // Read addresses
  input  logic [ADDR_W-1:0]  rs1,
  input  logic [ADDR_W-1:0]  rs2,

  // Raw selected entries, check bits included
  output logic [ENTRY_W-1:0] rs1_entry,
  output logic [ENTRY_W-1:0] rs2_entry
);

  // Entry array
  // Entry 0 holds ENTRY_RESET for ever once reset has run
  logic [ENTRY_W-1:0] mem [NUM_REGS];

  // Qualified write strobe
  // x0 is hardwired to zero, so writes to it are dropped here
  logic               wr_en;

  // Encoded word to store
  logic [ENTRY_W-1:0] wr_entry;

  assign wr_en    = gpr_we && (gpr_waddr != '0);
  assign wr_entry = {ecc_encode(gpr_wdata), gpr_wdata};

  // Synchronous reset loads every entry with data 0 and code 6'h2A
  // Writes become visible on the cycle after the strobe
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NUM_REGS; i++) begin
        mem[i] <= ENTRY_RESET;
      end
    end else if (wr_en) begin
      mem[gpr_waddr] <= wr_entry;
    end
  end

  // Asynchronous read of both ports
  // No write bypass, a same-cycle read sees the old entry
  assign rs1_entry = mem[rs1];
  assign rs2_entry = mem[rs2];

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_i,
  output logic rst_ni
);

  // Free running clock, 20 ns per half period
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Reset held for 8 rising edges
  // Released on a falling edge, well away from the sampling edge
  initial begin
    rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
  end

endmodule

// ==== tb_rf_ecc.sv ====
`timescale 1ns/1ps

module tb_rf_ecc
  import rf_ecc_pkg::*;
();

  // Sequence below runs about 960 cycles, limit set near twice that
  localparam int unsigned TIMEOUT_CYCLES = 2000;
  localparam int unsigned RNG_SEED       = 79239;
  localparam int unsigned NUM_WRITES     = 400;
  localparam int unsigned FAULT_ROUNDS   = 60;
  localparam int unsigned STUCK_ROUNDS   = 10;

  logic              clk_i;
  logic              rst_ni;
  logic              gpr_we;
  logic [ADDR_W-1:0] gpr_waddr;
  logic [DATA_W-1:0] gpr_wdata;
  logic [ADDR_W-1:0] rs1;
  logic [ADDR_W-1:0] rs2;
  logic [DATA_W-1:0] rs1_rdata;
  logic [DATA_W-1:0] rs2_rdata;
  logic              alert_major;
  logic              check_failed;
  int unsigned       cycle_count = 0;

  tb_clock_gen u_tb_clock_gen (
    .clk_i  (clk_i),
    .rst_ni (rst_ni)
  );

  rf_ecc_regfile u_rf_ecc_regfile (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .gpr_we      (gpr_we),
    .gpr_waddr   (gpr_waddr),
    .gpr_wdata   (gpr_wdata),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_rdata   (rs1_rdata),
    .rs2_rdata   (rs2_rdata),
    .alert_major (alert_major)
  );

  rf_ecc_assert u_rf_ecc_assert (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .gpr_we       (gpr_we),
    .gpr_waddr    (gpr_waddr),
    .gpr_wdata    (gpr_wdata),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_rdata    (rs1_rdata),
    .rs2_rdata    (rs2_rdata),
    .alert_major  (alert_major),
    .mem          (u_rf_ecc_regfile.u_rf_ecc_storage.mem),
    .check_failed (check_failed)
  );

  task automatic stop_with_failure(input string reason);
    $display("Verification failed");
    $fatal(1, "%s", reason);
  endtask

  // Inputs change on the falling edge and hold for one full cycle
  task automatic drive_cycle(input logic we, input logic [ADDR_W-1:0] waddr,
                             input logic [DATA_W-1:0] wdata,
                             input logic [ADDR_W-1:0] r1, input logic [ADDR_W-1:0] r2);
    gpr_we    = we;
    gpr_waddr = waddr;
    gpr_wdata = wdata;
    rs1       = r1;
    rs2       = r2;
    @(negedge clk_i);
  endtask

  function automatic logic [ADDR_W-1:0] pick_nonzero();
    return ADDR_W'(1 + ($urandom % (NUM_REGS - 1)));
  endfunction

  // Direct overwrite of one stored entry
  task automatic poke_entry(input logic [ADDR_W-1:0] r, input logic [ENTRY_W-1:0] value);
    u_rf_ecc_regfile.u_rf_ecc_storage.mem[r] = value;
  endtask

  // One or two distinct bit flips anywhere in the entry
  function automatic logic [ENTRY_W-1:0] flip_bits(input logic [ENTRY_W-1:0] e,
                                                   input logic two_bits);
    int unsigned        b0;
    int unsigned        b1;
    logic [ENTRY_W-1:0] mask;
    b0   = $urandom % ENTRY_W;
    b1   = (b0 + 1 + ($urandom % (ENTRY_W - 1))) % ENTRY_W;
    mask = ENTRY_W'(1) << b0;
    if (two_bits) begin
      mask = mask | (ENTRY_W'(1) << b1);
    end
    return e ^ mask;
  endfunction

  // Corrupt r, read it on each port with idle cycles between, then repair it with fix
  task automatic fault_round(input logic [ADDR_W-1:0] r, input logic [ENTRY_W-1:0] bad,
                             input logic [DATA_W-1:0] fix);
    logic [ADDR_W-1:0] other;
    other = ADDR_W'((r % (NUM_REGS - 1)) + 1);
    poke_entry(r, bad);
    drive_cycle(1'b0, '0, '0, other, '0);
    drive_cycle(1'b0, '0, '0, r, '0);
    drive_cycle(1'b0, '0, '0, other, other);
    drive_cycle(1'b0, '0, '0, '0, r);
    drive_cycle(1'b1, r, fix, other, '0);
    drive_cycle(1'b0, '0, '0, r, r);
  endtask

  initial begin : stimulus
    logic [ADDR_W-1:0]  r;
    logic [ADDR_W-1:0]  last_w;
    logic [ENTRY_W-1:0] entry;
    void'($urandom(RNG_SEED));
    gpr_we    = 1'b0;
    gpr_waddr = '0;
    gpr_wdata = '0;
    rs1       = '0;
    rs2       = '0;
    @(posedge rst_ni);
    @(negedge clk_i);

    // Reset image, every register reads zero on both ports
    for (int unsigned i = 0; i < NUM_REGS; i++) begin
      drive_cycle(1'b0, '0, '0, ADDR_W'(i), ADDR_W'(NUM_REGS - 1 - i));
    end

    // Random writes, rs1 follows the previous write address
    last_w = '0;
    for (int unsigned n = 0; n < NUM_WRITES; n++) begin
      r = ADDR_W'($urandom % NUM_REGS);
      // Every eighth write aims at x0
      if (n % 8 == 0) begin
        r = '0;
      end
      drive_cycle(1'b1, r, $urandom, last_w, ADDR_W'($urandom % NUM_REGS));
      last_w = r;
    end
    for (int unsigned i = 0; i < NUM_REGS; i++) begin
      drive_cycle(1'b0, '0, '0, ADDR_W'(i), ADDR_W'(i));
    end

    // Single and double bit flips, alternating
    for (int unsigned n = 0; n < FAULT_ROUNDS; n++) begin
      r     = pick_nonzero();
      entry = u_rf_ecc_regfile.u_rf_ecc_storage.mem[r];
      fault_round(r, flip_bits(entry, n[0]), $urandom);
    end

    // Stuck words, all zeros then all ones
    // Each is repaired by writing the matching data word
    for (int unsigned n = 0; n < STUCK_ROUNDS; n++) begin
      fault_round(pick_nonzero(), '0, '0);
      fault_round(pick_nonzero(), '1, '1);
    end

    // Garbage in entry 0 is never checked
    poke_entry('0, '1);
    repeat (4) drive_cycle(1'b0, '0, '0, '0, '0);
    poke_entry('0, ENTRY_RESET);
    drive_cycle(1'b0, '0, '0, '0, '0);
    drive_cycle(1'b0, '0, '0, '0, '0);

    if (check_failed) begin
      stop_with_failure("a check failed during the run");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

  // First assertion failure ends the run
  initial begin : watch_checks
    wait (check_failed);
    stop_with_failure("an assertion in the checker failed");
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_failure("timeout, the test sequence did not finish");
    end
  end

endmodule
